//--- build.f
design/exec_pkg.sv
design/exec_alu.sv
design/exec_regfile.sv
design/exec_hazard.sv
design/exec_stage_e1.sv
design/exec_stage_e2.sv
design/exec_top.sv
verification/tb_clk_gen.sv
verification/tb_exec_checker.sv
verification/tb_exec_top.sv

//--- design/exec_alu.sv
// combinational integer alu used by the first execute stage
`timescale 1ns/100ps

module exec_alu (
    input  exec_pkg::word_t [1:0] i_alu_operands,
    input  exec_pkg::alu_op_e     i_alu_operation,
    output exec_pkg::word_t       o_alu_result
);
    import exec_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    // operand one is index 0
    assign op_a  = i_alu_operands[0];
    assign op_b  = i_alu_operands[1];
    // only the low five bits shift
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (i_alu_operation)
            ALU_OP_ADD:  o_alu_result = op_a + op_b;
            ALU_OP_SUB:  o_alu_result = op_a - op_b;
            ALU_OP_SLL:  o_alu_result = op_a << shamt;
            // compares give a single bit result
            ALU_OP_SLT:  o_alu_result = {31'h0, $signed(op_a) < $signed(op_b)};
            ALU_OP_SLTU: o_alu_result = {31'h0, op_a < op_b};
            ALU_OP_XOR:  o_alu_result = op_a ^ op_b;
            ALU_OP_SRL:  o_alu_result = op_a >> shamt;
            // arithmetic shift keeps the sign
            ALU_OP_SRA:  o_alu_result = word_t'($signed(op_a) >>> shamt);
            ALU_OP_OR:   o_alu_result = op_a | op_b;
            ALU_OP_AND:  o_alu_result = op_a & op_b;
            // unused encodings
            default:     o_alu_result = '0;
        endcase
    end

endmodule

//--- design/exec_hazard.sv
// bypass source selection for e1 operands and the one-cycle csr read-after-write stall
`timescale 1ns/100ps

module exec_hazard (
    input  exec_pkg::issue_s    i_issue,
    input  exec_pkg::e1_to_e2_s i_e2_rec,
    input  exec_pkg::wb_s       i_wb,
    output exec_pkg::bypass_e   o_rs1_bypass,
    output exec_pkg::bypass_e   o_rs2_bypass,
    output logic                o_issue_ready
);
    import exec_pkg::*;

    logic e2_writes;
    logic wb_writes;
    logic uses_csr;
    logic csr_raw;

    // e2 holds the younger result so it wins over writeback
    function automatic bypass_e pick_source(
        input reg_idx_t src_idx,
        input logic     e2_hit_en,
        input reg_idx_t e2_idx,
        input logic     wb_hit_en,
        input reg_idx_t wb_idx
    );
        bypass_e sel;
        sel = BYPASS_RF;
        if (e2_hit_en && (e2_idx == src_idx)) begin
            sel = BYPASS_E2;
        end else if (wb_hit_en && (wb_idx == src_idx)) begin
            sel = BYPASS_WB;
        end
        return sel;
    endfunction

    // later stages that will write a real register
    assign e2_writes = i_e2_rec.valid && i_e2_rec.rd_we && (i_e2_rec.rd_idx != '0);
    assign wb_writes = i_wb.valid && i_wb.rd_we && (i_wb.rd_idx != '0);

    always_comb begin
        o_rs1_bypass = pick_source(i_issue.rs1_idx, e2_writes, i_e2_rec.rd_idx,
                                   wb_writes, i_wb.rd_idx);
        o_rs2_bypass = pick_source(i_issue.rs2_idx, e2_writes, i_e2_rec.rd_idx,
                                   wb_writes, i_wb.rd_idx);
    end

    // csr value needed by the issuing instruction
    assign uses_csr = (i_issue.alu_op1_src == ALU_OP1_SRC_CSR) || (i_issue.rd_src == RD_SRC_CSR);

    // pending csr update in e2 lands in the bank next edge
    assign csr_raw = i_issue.valid && uses_csr && i_e2_rec.valid &&
                     (i_e2_rec.csr_op != CSR_OP_NONE) && (i_e2_rec.csr_idx == i_issue.csr_idx);

    // stall for one cycle while e1 takes a bubble
    assign o_issue_ready = !csr_raw;

endmodule

//--- design/exec_pkg.sv
// shared types and pipeline records for the execute slice, imported by every module
package exec_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    // four scratch csrs
    typedef logic [1:0]  csr_idx_t;

    // alu operations
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'h0,
        ALU_OP_SUB  = 4'h1,
        ALU_OP_SLL  = 4'h2,
        ALU_OP_SLT  = 4'h3,
        ALU_OP_SLTU = 4'h4,
        ALU_OP_XOR  = 4'h5,
        ALU_OP_SRL  = 4'h6,
        ALU_OP_SRA  = 4'h7,
        ALU_OP_OR   = 4'h8,
        ALU_OP_AND  = 4'h9
    } alu_op_e;

    // operand one source
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1  = 2'h0,
        ALU_OP1_SRC_PC   = 2'h1,
        ALU_OP1_SRC_CSR  = 2'h2,
        ALU_OP1_SRC_ZERO = 2'h3
    } alu_op1_src_e;

    // operand two source
    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS1  = 2'h0,
        ALU_OP2_SRC_RS2  = 2'h1,
        ALU_OP2_SRC_IMM  = 2'h2,
        ALU_OP2_SRC_FOUR = 2'h3
    } alu_op2_src_e;

    // destination value source
    typedef enum logic {
        RD_SRC_ALU = 1'b0,
        RD_SRC_CSR = 1'b1
    } rd_src_e;

    // csr update, source is always the alu result
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'h0,
        CSR_OP_WRITE = 2'h1,
        CSR_OP_SET   = 2'h2,
        CSR_OP_CLEAR = 2'h3
    } csr_op_e;

    // where an e1 register operand comes from
    typedef enum logic [1:0] {
        BYPASS_RF = 2'h0,
        BYPASS_E2 = 2'h1,
        BYPASS_WB = 2'h2
    } bypass_e;

    // decoded instruction at the issue port
    typedef struct packed {
        logic         valid;
        logic [29:0]  pc_word;
        reg_idx_t     rs1_idx;
        reg_idx_t     rs2_idx;
        alu_op1_src_e alu_op1_src;
        alu_op2_src_e alu_op2_src;
        alu_op_e      alu_op;
        word_t        immediate;
        reg_idx_t     rd_idx;
        logic         rd_we;
        rd_src_e      rd_src;
        csr_op_e      csr_op;
        csr_idx_t     csr_idx;
    } issue_s;

    // e1 output register
    typedef struct packed {
        logic     valid;
        reg_idx_t rd_idx;
        logic     rd_we;
        rd_src_e  rd_src;
        csr_op_e  csr_op;
        csr_idx_t csr_idx;
        word_t    old_csr_value;
        word_t    alu_result;
    } e1_to_e2_s;

    // writeback record, also the regfile write port
    typedef struct packed {
        logic     valid;
        reg_idx_t rd_idx;
        logic     rd_we;
        word_t    rd_value;
    } wb_s;

endpackage

//--- design/exec_regfile.sv
// integer register file with two combinational read ports and one write port from writeback
`timescale 1ns/100ps

module exec_regfile (
    input  logic               i_clk,
    input  exec_pkg::reg_idx_t i_rs1_idx,
    input  exec_pkg::reg_idx_t i_rs2_idx,
    output exec_pkg::word_t    o_rs1_rdata,
    output exec_pkg::word_t    o_rs2_rdata,
    input  exec_pkg::wb_s      i_wb
);
    import exec_pkg::*;

    // x0 has no storage
    word_t regs [31:1];

    // no write-through, the hazard unit forwards from writeback
    assign o_rs1_rdata = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
    assign o_rs2_rdata = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

    // write ignored for x0
    always_ff @(posedge i_clk) begin
        if (i_wb.valid && i_wb.rd_we && (i_wb.rd_idx != '0)) begin
            regs[i_wb.rd_idx] <= i_wb.rd_value;
        end
    end

endmodule

//--- design/exec_stage_e1.sv
// first execute stage of the slice with operand bypass and select, the alu and the e1-to-e2 register
`timescale 1ns/100ps

module exec_stage_e1 (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  exec_pkg::issue_s    i_issue,
    input  logic                i_issue_ready,
    input  logic                i_flush,
    input  exec_pkg::word_t     i_rs1_rdata,
    input  exec_pkg::word_t     i_rs2_rdata,
    input  exec_pkg::bypass_e   i_rs1_bypass,
    input  exec_pkg::bypass_e   i_rs2_bypass,
    input  exec_pkg::word_t     i_e2_fwd,
    input  exec_pkg::word_t     i_wb_fwd,
    input  exec_pkg::word_t     i_csr_rdata,
    output exec_pkg::e1_to_e2_s o_e1_to_e2
);
    import exec_pkg::*;

    word_t [1:0] alu_operands;
    word_t       alu_result;
    word_t       rs1;
    word_t       rs2;
    logic        accept;

    // bypass mux shared by both register operands
    function automatic word_t bypass_mux(
        input bypass_e sel,
        input word_t   rf_value,
        input word_t   e2_value,
        input word_t   wb_value
    );
        word_t value;
        unique case (sel)
            BYPASS_E2: value = e2_value;
            BYPASS_WB: value = wb_value;
            default:   value = rf_value;
        endcase
        return value;
    endfunction

    exec_alu i_alu (
        .i_alu_operands (alu_operands),
        .i_alu_operation(i_issue.alu_op),
        .o_alu_result   (alu_result)
    );

    // resolved register values
    always_comb begin
        rs1 = bypass_mux(i_rs1_bypass, i_rs1_rdata, i_e2_fwd, i_wb_fwd);
        rs2 = bypass_mux(i_rs2_bypass, i_rs2_rdata, i_e2_fwd, i_wb_fwd);
    end

    // op1 select with the pc word turned into a byte address
    always_comb begin
        unique case (i_issue.alu_op1_src)
            ALU_OP1_SRC_RS1:  alu_operands[0] = rs1;
            ALU_OP1_SRC_PC:   alu_operands[0] = {i_issue.pc_word, 2'b00};
            ALU_OP1_SRC_CSR:  alu_operands[0] = i_csr_rdata;
            ALU_OP1_SRC_ZERO: alu_operands[0] = '0;
        endcase
    end

    // op2 select
    always_comb begin
        unique case (i_issue.alu_op2_src)
            ALU_OP2_SRC_RS1:  alu_operands[1] = rs1;
            ALU_OP2_SRC_RS2:  alu_operands[1] = rs2;
            ALU_OP2_SRC_IMM:  alu_operands[1] = i_issue.immediate;
            ALU_OP2_SRC_FOUR: alu_operands[1] = 32'h4;
        endcase
    end

    // handshake at this edge
    assign accept = i_issue.valid && i_issue_ready;

    // stall or flush leaves a bubble
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_e1_to_e2.valid <= 1'b0;
        end else begin
            o_e1_to_e2.valid <= accept && !i_flush;
        end
    end

    // record payload
    always_ff @(posedge i_clk) begin
        o_e1_to_e2.rd_idx        <= i_issue.rd_idx;
        o_e1_to_e2.rd_we         <= i_issue.rd_we;
        o_e1_to_e2.rd_src        <= i_issue.rd_src;
        o_e1_to_e2.csr_op        <= i_issue.csr_op;
        o_e1_to_e2.csr_idx       <= i_issue.csr_idx;
        o_e1_to_e2.old_csr_value <= i_csr_rdata;
        o_e1_to_e2.alu_result    <= alu_result;
    end

    // the bubble taken on a stall clears the csr hazard within one cycle
    a_single_cycle_stall: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !i_issue_ready |=> i_issue_ready
    );

endmodule

//--- design/exec_stage_e2.sv
// second execute stage holding the scratch csr bank, the csr commit and the writeback register
`timescale 1ns/100ps

module exec_stage_e2 (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_flush,
    input  exec_pkg::e1_to_e2_s i_e1_to_e2,
    input  exec_pkg::csr_idx_t  i_csr_rd_idx,
    output exec_pkg::word_t     o_csr_rdata,
    output exec_pkg::word_t     o_fwd_value,
    output exec_pkg::wb_s       o_wb
);
    import exec_pkg::*;

    word_t csr_q [4];
    word_t csr_cur;
    word_t csr_next;
    logic  commit;

    // read for the instruction at issue
    assign o_csr_rdata = csr_q[i_csr_rd_idx];

    // flush kills the record sitting here
    assign commit = i_e1_to_e2.valid && !i_flush;

    // destination value that e1 also forwards
    assign o_fwd_value = (i_e1_to_e2.rd_src == RD_SRC_CSR) ? i_e1_to_e2.old_csr_value
                                                           : i_e1_to_e2.alu_result;

    // read-modify-write on the addressed csr
    assign csr_cur = csr_q[i_e1_to_e2.csr_idx];

    always_comb begin
        unique case (i_e1_to_e2.csr_op)
            CSR_OP_WRITE: csr_next = i_e1_to_e2.alu_result;
            CSR_OP_SET:   csr_next = csr_cur | i_e1_to_e2.alu_result;
            CSR_OP_CLEAR: csr_next = csr_cur & ~i_e1_to_e2.alu_result;
            // no update
            default:      csr_next = csr_cur;
        endcase
    end

    // csr bank cleared by reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 4; i++) begin
                csr_q[i] <= '0;
            end
        end else if (commit && (i_e1_to_e2.csr_op != CSR_OP_NONE)) begin
            csr_q[i_e1_to_e2.csr_idx] <= csr_next;
        end
    end

    // writeback valid
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= commit;
        end
    end

    // writeback payload
    always_ff @(posedge i_clk) begin
        o_wb.rd_idx   <= i_e1_to_e2.rd_idx;
        o_wb.rd_we    <= i_e1_to_e2.rd_we;
        o_wb.rd_value <= o_fwd_value;
    end

    // old csr value of the next record is never stale after a csr update here
    a_no_stale_csr_value: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_e1_to_e2.valid && (i_e1_to_e2.csr_op != CSR_OP_NONE))
        |=> !(i_e1_to_e2.valid && (i_e1_to_e2.rd_src == RD_SRC_CSR) &&
              (i_e1_to_e2.csr_idx == $past(i_e1_to_e2.csr_idx)))
    );

endmodule

//--- design/exec_top.sv
// top level of the execute slice, connects issue port, regfile, hazard unit and both stages
`timescale 1ns/100ps

module exec_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  exec_pkg::issue_s i_issue,
    output logic             o_issue_ready,
    input  logic             i_flush,
    output exec_pkg::wb_s    o_wb
);
    import exec_pkg::*;

    // register file reads
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    // hazard decisions
    bypass_e   rs1_bypass;
    bypass_e   rs2_bypass;
    // stage to stage
    e1_to_e2_s e1_to_e2;
    word_t     e2_fwd;
    word_t     csr_rdata;

    exec_regfile i_regfile (
        .i_clk      (i_clk),
        .i_rs1_idx  (i_issue.rs1_idx),
        .i_rs2_idx  (i_issue.rs2_idx),
        .o_rs1_rdata(rs1_rdata),
        .o_rs2_rdata(rs2_rdata),
        .i_wb       (o_wb)
    );

    exec_hazard i_hazard (
        .i_issue      (i_issue),
        .i_e2_rec     (e1_to_e2),
        .i_wb         (o_wb),
        .o_rs1_bypass (rs1_bypass),
        .o_rs2_bypass (rs2_bypass),
        .o_issue_ready(o_issue_ready)
    );

    exec_stage_e1 i_e1 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_issue      (i_issue),
        .i_issue_ready(o_issue_ready),
        .i_flush      (i_flush),
        .i_rs1_rdata  (rs1_rdata),
        .i_rs2_rdata  (rs2_rdata),
        .i_rs1_bypass (rs1_bypass),
        .i_rs2_bypass (rs2_bypass),
        .i_e2_fwd     (e2_fwd),
        // writeback forward is the registered wb value
        .i_wb_fwd     (o_wb.rd_value),
        .i_csr_rdata  (csr_rdata),
        .o_e1_to_e2   (e1_to_e2)
    );

    exec_stage_e2 i_e2 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_e1_to_e2  (e1_to_e2),
        .i_csr_rd_idx(i_issue.csr_idx),
        .o_csr_rdata (csr_rdata),
        .o_fwd_value (e2_fwd),
        .o_wb        (o_wb)
    );

endmodule

//--- verification/tb_clk_gen.sv
// testbench clock and synchronous reset source, instantiated once by the testbench top
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int CLK_PERIOD   = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
    end

    // reset released just after an edge, same offset as the stimulus
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #10 o_rst_n = 1'b1;
    end

endmodule

//--- verification/tb_exec_checker.sv
// testbench checker with an in-order reference model that compares every writeback of the slice
`timescale 1ns/100ps

module tb_exec_checker (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  exec_pkg::issue_s i_issue,
    input  logic             i_issue_ready,
    input  logic             i_flush,
    input  exec_pkg::wb_s    i_wb,
    output int               o_errors,
    output int               o_checked,
    output int               o_outstanding
);
    import exec_pkg::*;

    // accepted but still flushable
    typedef struct packed {
        issue_s ins;
        int     accept_edge;
    } pending_s;

    // committed in the model with its writeback due at a known edge
    typedef struct packed {
        wb_s wb;
        int  due_edge;
    } expect_s;

    word_t    model_regs [32];
    word_t    model_csrs [4];
    pending_s pending [$];
    expect_s  expected [$];
    int       edge_no;

    // unwritten registers start unknown as in the regfile
    initial begin
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = (r == 0) ? '0 : 'x;
        end
    end

    // integer alu rules with the shift amount from the low five bits
    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_OP_ADD:  return a + b;
            ALU_OP_SUB:  return a + ~b + 32'd1;
            ALU_OP_SLL:  return a << sh;
            // signed compare by biasing the sign bit
            ALU_OP_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_OP_XOR:  return a ^ b;
            ALU_OP_SRL:  return a >> sh;
            // fill the vacated top bits with the sign
            ALU_OP_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_OP_OR:   return a | b;
            ALU_OP_AND:  return a & b;
            default:     return '0;
        endcase
    endfunction

    // expected writeback and new csr value from the model state
    function automatic wb_s expected_wb(input issue_s ins, output word_t csr_new);
        word_t op1;
        word_t op2;
        word_t old_csr;
        word_t result;
        wb_s   wb;
        old_csr = model_csrs[ins.csr_idx];
        case (ins.alu_op1_src)
            ALU_OP1_SRC_RS1: op1 = model_regs[ins.rs1_idx];
            // byte address is the pc word times four
            ALU_OP1_SRC_PC:  op1 = word_t'(ins.pc_word) * 32'd4;
            ALU_OP1_SRC_CSR: op1 = old_csr;
            default:         op1 = '0;
        endcase
        case (ins.alu_op2_src)
            ALU_OP2_SRC_RS1: op2 = model_regs[ins.rs1_idx];
            ALU_OP2_SRC_RS2: op2 = model_regs[ins.rs2_idx];
            ALU_OP2_SRC_IMM: op2 = ins.immediate;
            default:         op2 = 32'd4;
        endcase
        result = alu_model(ins.alu_op, op1, op2);
        case (ins.csr_op)
            CSR_OP_WRITE: csr_new = result;
            CSR_OP_SET:   csr_new = old_csr | result;
            CSR_OP_CLEAR: csr_new = old_csr & ~result;
            default:      csr_new = old_csr;
        endcase
        wb.valid    = 1'b1;
        wb.rd_idx   = ins.rd_idx;
        wb.rd_we    = ins.rd_we;
        wb.rd_value = (ins.rd_src == RD_SRC_CSR) ? old_csr : result;
        return wb;
    endfunction

    always @(posedge i_clk) begin
        pending_s p;
        expect_s  e;
        word_t    csr_new;
        if (!i_rst_n) begin
            pending.delete();
            expected.delete();
            edge_no = 0;
            for (int c = 0; c < 4; c++) begin
                model_csrs[c] = '0;
            end
        end else begin
            edge_no++;
            // o_wb seen here was registered at the previous edge
            if (i_wb.valid) begin
                if (expected.size() == 0) begin
                    $display("writeback for x%0d at %0t with no instruction left to retire",
                             i_wb.rd_idx, $time);
                    o_errors++;
                end else begin
                    e = expected.pop_front();
                    o_checked++;
                    if (e.due_edge != edge_no) begin
                        $display("writeback for x%0d at %0t came %0d edges off its latency",
                                 i_wb.rd_idx, $time, edge_no - e.due_edge);
                        o_errors++;
                    end
                    if (i_wb !== e.wb) begin
                        $display("Error at %0t: wb x%0d we %0b %h, expected x%0d we %0b %h",
                                 $time, i_wb.rd_idx, i_wb.rd_we, i_wb.rd_value,
                                 e.wb.rd_idx, e.wb.rd_we, e.wb.rd_value);
                        o_errors++;
                    end
                end
            end else if ((expected.size() != 0) && (expected[0].due_edge == edge_no)) begin
                e = expected.pop_front();
                $display("writeback for x%0d missing at %0t", e.wb.rd_idx, $time);
                o_errors++;
            end
            // handshake at this edge
            if (i_issue.valid && i_issue_ready) begin
                p.ins         = i_issue;
                p.accept_edge = edge_no;
                pending.push_back(p);
            end
            // flush kills this edge's accept and the one in e2
            if (i_flush) begin
                while ((pending.size() != 0) && (pending[$].accept_edge >= edge_no - 1)) begin
                    void'(pending.pop_back());
                end
            end
            // past both flush edges and safe to retire into the model
            while ((pending.size() != 0) && (pending[0].accept_edge <= edge_no - 1)) begin
                p          = pending.pop_front();
                e.wb       = expected_wb(p.ins, csr_new);
                e.due_edge = p.accept_edge + 2;
                model_csrs[p.ins.csr_idx] = csr_new;
                if (p.ins.rd_we && (p.ins.rd_idx != '0)) begin
                    model_regs[p.ins.rd_idx] = e.wb.rd_value;
                end
                expected.push_back(e);
            end
        end
        o_outstanding = pending.size() + expected.size();
    end

endmodule

//--- verification/tb_exec_top.sv
// testbench top for the execute slice, drives directed and random instruction streams
`timescale 1ns/100ps

module tb_exec_top;
    import exec_pkg::*;

    // edges any single wait may take
    localparam int WAIT_LIMIT = 50;

    logic   clk;
    logic   rst_n;
    issue_s issue;
    logic   issue_ready;
    logic   flush;
    wb_s    wb;
    int     errors;
    int     checked;
    int     outstanding;
    int     local_errors;
    int     last_errors;
    int     tests_done;
    integer seed;

    tb_clk_gen #(
        .CLK_PERIOD  (100),
        .RESET_CYCLES(8)
    ) i_clk_gen (
        .o_clk  (clk),
        .o_rst_n(rst_n)
    );

    exec_top i_dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_issue      (issue),
        .o_issue_ready(issue_ready),
        .i_flush      (flush),
        .o_wb         (wb)
    );

    tb_exec_checker i_checker (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_issue      (issue),
        .i_issue_ready(issue_ready),
        .i_flush      (flush),
        .i_wb         (wb),
        .o_errors     (errors),
        .o_checked    (checked),
        .o_outstanding(outstanding)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $finish;
    endtask

    // no csr op, rd written from the alu
    function automatic issue_s make_instr(input alu_op_e op, input alu_op1_src_e src1,
                                          input alu_op2_src_e src2, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input word_t imm,
                                          input reg_idx_t rd);
        issue_s ins;
        ins             = '0;
        ins.valid       = 1'b1;
        ins.alu_op      = op;
        ins.alu_op1_src = src1;
        ins.alu_op2_src = src2;
        ins.rs1_idx     = rs1;
        ins.rs2_idx     = rs2;
        ins.immediate   = imm;
        ins.rd_idx      = rd;
        ins.rd_we       = 1'b1;
        return ins;
    endfunction

    // called 10 ns after an edge, held until an edge sees ready
    task automatic send_instr(input issue_s ins, input logic flush_now, output int stalls);
        logic taken;
        taken  = 1'b0;
        stalls = 0;
        issue  = ins;
        flush  = flush_now;
        while (!taken) begin
            if (stalls >= WAIT_LIMIT) begin
                abort_run("timeout: o_issue_ready stayed low while an instruction waited");
            end
            @(posedge clk);
            if (issue_ready) begin
                taken = 1'b1;
            end else begin
                stalls++;
            end
            #10;
            // single-cycle strobe
            flush = 1'b0;
        end
        issue.valid = 1'b0;
    endtask

    task automatic expect_stalls(input int got, input int want);
        if (got != want) begin
            $display("Error at %0t: issue waited %0d cycles, expected %0d", $time, got, want);
            local_errors++;
        end
    endtask

    // until the checker has nothing left to retire
    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (outstanding != 0) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("timeout: writebacks still outstanding after the stream ended");
            end
            @(posedge clk);
            #10;
            waited++;
        end
    endtask

    task automatic report_test(input string name);
        drain_pipeline();
        tests_done++;
        $display("test %0d %s finished with %0d errors", tests_done, name,
                 errors + local_errors - last_errors);
        last_errors = errors + local_errors;
    endtask

    initial begin
        issue_s ins;
        int     stalls;
        int     waited;
        logic   flush_now;
        issue        = '0;
        flush        = 1'b0;
        seed         = 32'ha027;
        local_errors = 0;
        last_errors  = 0;
        tests_done   = 0;
        waited       = 0;
        while (rst_n !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("timeout: reset was never released");
            end
            @(posedge clk);
            waited++;
        end
        #10;

        // idle after reset
        repeat (4) begin
            @(posedge clk);
            if ((wb.valid !== 1'b0) || (issue_ready !== 1'b1)) begin
                $display("Error at %0t: wb valid %b ready %b while idle", $time, wb.valid,
                         issue_ready);
                local_errors++;
            end
        end
        #10;
        report_test("reset state");

        // every register gets a value that depends on its whole index
        for (int r = 1; r < 32; r++) begin
            send_instr(make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0,
                                  32'h9e37_79b9 * r, reg_idx_t'(r)), 1'b0, stalls);
        end
        send_instr(make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0,
                              32'h8000_0001, 1), 1'b0, stalls);
        send_instr(make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0,
                              32'h7fff_fff0, 2), 1'b0, stalls);
        send_instr(make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0,
                              32'hffff_fffb, 3), 1'b0, stalls);
        // shift amount 37 keeps only 5
        send_instr(make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0, 37, 4),
                   1'b0, stalls);
        for (int op = 0; op < 10; op++) begin
            send_instr(make_instr(alu_op_e'(op), ALU_OP1_SRC_RS1, ALU_OP2_SRC_RS2, 1, 4, 0, 5),
                       1'b0, stalls);
            // signed and unsigned compares disagree here
            send_instr(make_instr(alu_op_e'(op), ALU_OP1_SRC_RS1, ALU_OP2_SRC_RS2, 3, 2, 0, 6),
                       1'b0, stalls);
            send_instr(make_instr(alu_op_e'(op), ALU_OP1_SRC_RS1, ALU_OP2_SRC_IMM, 1, 0,
                                  32'hffff_ffe3, 7), 1'b0, stalls);
            // x0 write must be dropped
            send_instr(make_instr(alu_op_e'(op), ALU_OP1_SRC_RS1, ALU_OP2_SRC_IMM, 2, 0, 99, 0),
                       1'b0, stalls);
            send_instr(make_instr(ALU_OP_OR, ALU_OP1_SRC_RS1, ALU_OP2_SRC_RS2, 0, 0, 0, 8),
                       1'b0, stalls);
        end
        report_test("alu operations");

        // dependent pairs at distance one, two and three
        for (int d = 1; d <= 3; d++) begin
            send_instr(make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0, 100 * d, 10),
                       1'b0, stalls);
            for (int f = 1; f < d; f++) begin
                send_instr(make_instr(ALU_OP_XOR, ALU_OP1_SRC_RS1, ALU_OP2_SRC_IMM, 20, 0, f, 20),
                           1'b0, stalls);
            end
            send_instr(make_instr(ALU_OP_ADD, ALU_OP1_SRC_RS1, ALU_OP2_SRC_RS2, 10, 10, 0, 11),
                       1'b0, stalls);
            send_instr(make_instr(ALU_OP_SUB, ALU_OP1_SRC_RS1, ALU_OP2_SRC_RS2, 11, 10, 0, 12),
                       1'b0, stalls);
        end
        report_test("forwarding");

        // write, set, clear on csr 1, old value to rd
        ins         = make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0, 32'hf0, 5);
        ins.csr_op  = CSR_OP_WRITE;
        ins.csr_idx = 2'd1;
        ins.rd_src  = RD_SRC_CSR;
        send_instr(ins, 1'b0, stalls);
        expect_stalls(stalls, 0);
        ins.csr_op    = CSR_OP_SET;
        ins.immediate = 32'h0f;
        ins.rd_idx    = 6;
        send_instr(ins, 1'b0, stalls);
        expect_stalls(stalls, 1);
        ins.csr_op    = CSR_OP_CLEAR;
        ins.immediate = 32'h3c;
        ins.rd_idx    = 7;
        send_instr(ins, 1'b0, stalls);
        expect_stalls(stalls, 1);
        // read through op1 right behind the clear
        ins         = make_instr(ALU_OP_ADD, ALU_OP1_SRC_CSR, ALU_OP2_SRC_IMM, 0, 0, 0, 8);
        ins.csr_idx = 2'd1;
        send_instr(ins, 1'b0, stalls);
        expect_stalls(stalls, 1);
        // different index, no stall
        ins         = make_instr(ALU_OP_ADD, ALU_OP1_SRC_ZERO, ALU_OP2_SRC_IMM, 0, 0, 32'h55, 9);
        ins.csr_op  = CSR_OP_WRITE;
        ins.csr_idx = 2'd2;
        send_instr(ins, 1'b0, stalls);
        ins         = make_instr(ALU_OP_ADD, ALU_OP1_SRC_CSR, ALU_OP2_SRC_IMM, 0, 0, 1, 10);
        ins.csr_idx = 2'd1;
        send_instr(ins, 1'b0, stalls);
        expect_stalls(stalls, 0);
        report_test("csr access");

        // pc plus four and pc plus immediate, last one wraps
        for (int k = 1; k <= 3; k++) begin
            ins         = make_instr(ALU_OP_ADD, ALU_OP1_SRC_PC, ALU_OP2_SRC_FOUR, 0, 0, 0, 13);
            ins.pc_word = 30'(32'h1555_5555 * k);
            send_instr(ins, 1'b0, stalls);
            ins.alu_op2_src = ALU_OP2_SRC_IMM;
            ins.immediate   = 32'h0000_0100 * k;
            ins.rd_idx      = 14;
            send_instr(ins, 1'b0, stalls);
        end
        report_test("pc relative");

        // small register range for many hazards
        for (int n = 0; n < 200; n++) begin
            ins             = make_instr(ALU_OP_ADD, ALU_OP1_SRC_RS1, ALU_OP2_SRC_RS2, 0, 0, 0, 0);
            ins.alu_op      = alu_op_e'($unsigned($random(seed)) % 10);
            ins.alu_op1_src = alu_op1_src_e'($random(seed) & 3);
            ins.alu_op2_src = alu_op2_src_e'($random(seed) & 3);
            ins.rs1_idx     = reg_idx_t'($random(seed) & 7);
            ins.rs2_idx     = reg_idx_t'($random(seed) & 7);
            ins.rd_idx      = reg_idx_t'($random(seed) & 7);
            ins.immediate   = $random(seed);
            ins.pc_word     = 30'($random(seed));
            ins.rd_we       = 1'($random(seed));
            ins.rd_src      = rd_src_e'($random(seed) & 1);
            ins.csr_op      = csr_op_e'($random(seed) & 3);
            ins.csr_idx     = csr_idx_t'($random(seed) & 3);
            // roughly one flush in eight
            flush_now = (($random(seed) & 7) == 0);
            send_instr(ins, flush_now, stalls);
        end
        report_test("random with flush");

        $display("tests %0d, writebacks checked %0d, errors %0d", tests_done, checked,
                 errors + local_errors);
        if ((errors + local_errors) == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
